//--- common/aluPkg.sv
package aluPkg;

  //////////////////////////////
  // Operation classes
  //////////////////////////////
  typedef enum logic [2:0] {
    opReg   = 3'd0,  // Register-register
    opImm   = 3'd1,  // Register-immediate
    opReg32 = 3'd2,  // RV64 W-form, register
    opImm32 = 3'd3,  // RV64 W-form, immediate
    opAddr  = 3'd4   // Address generation, plain add
  } opClassT;

  // Control field widths
  localparam int F3_W   = 3;
  localparam int F7_W   = 7;
  localparam int SEL_W  = 3;
  localparam int BSEL_W = 2;

  // funct3 encodings
  localparam logic [F3_W-1:0] F3_ADD    = 3'b000;
  localparam logic [F3_W-1:0] F3_SLL    = 3'b001;  // Also bset/bclr/binv
  localparam logic [F3_W-1:0] F3_SLT    = 3'b010;
  localparam logic [F3_W-1:0] F3_SLTU   = 3'b011;
  localparam logic [F3_W-1:0] F3_XOR    = 3'b100;
  localparam logic [F3_W-1:0] F3_SR     = 3'b101;  // srl/sra, also bext
  localparam logic [F3_W-1:0] F3_OR     = 3'b110;
  localparam logic [F3_W-1:0] F3_AND    = 3'b111;
  localparam logic [F3_W-1:0] F3_CLMUL  = 3'b001;
  localparam logic [F3_W-1:0] F3_CLMULR = 3'b010;
  localparam logic [F3_W-1:0] F3_CLMULH = 3'b011;

  // funct7 encodings
  localparam logic [F7_W-1:0] F7_BASE      = 7'b0000000;
  localparam logic [F7_W-1:0] F7_ALT       = 7'b0100000;  // sub, sra
  localparam logic [F7_W-1:0] F7_ZBC       = 7'b0000101;
  localparam logic [F7_W-1:0] F7_BSET      = 7'b0010100;
  localparam logic [F7_W-1:0] F7_BCLR_BEXT = 7'b0100100;
  localparam logic [F7_W-1:0] F7_BINV      = 7'b0110100;

  // ALU result mux select
  localparam logic [SEL_W-1:0] SEL_SUM   = 3'b000;
  localparam logic [SEL_W-1:0] SEL_SHIFT = 3'b001;
  localparam logic [SEL_W-1:0] SEL_SLT   = 3'b010;
  localparam logic [SEL_W-1:0] SEL_SLTU  = 3'b011;
  localparam logic [SEL_W-1:0] SEL_XOR   = 3'b100;
  localparam logic [SEL_W-1:0] SEL_BEXT  = 3'b101;
  localparam logic [SEL_W-1:0] SEL_OR    = 3'b110;
  localparam logic [SEL_W-1:0] SEL_AND   = 3'b111;

  // Bit-manip group, one-hot
  localparam logic [BSEL_W-1:0] BSEL_NONE = 2'b00;
  localparam logic [BSEL_W-1:0] BSEL_ZBS  = 2'b01;
  localparam logic [BSEL_W-1:0] BSEL_ZBC  = 2'b10;

endpackage

//--- common/aluCtrlIf.sv
// Decoded ALU control, decoder to ALU
// clk and rstN only clock the checks on the ALU side
interface aluCtrlIf (
  input logic clk,
  input logic rstN
);

  logic                           w64;        // RV64 W-form
  logic                           subArith;   // Invert operand, arith shift
  logic                           aluOp;      // 0 forces plain add
  logic [aluPkg::SEL_W-1:0]  aluSelect;  // Result mux
  logic [aluPkg::BSEL_W-1:0] bSelect;    // Zbs/Zbc one-hot
  logic [aluPkg::F3_W-1:0]   funct3;     // Raw funct3 for shifter/clmul

  modport dec (
    output w64, subArith, aluOp, aluSelect, bSelect, funct3
  );

  modport exe (
    input clk, rstN,
    input w64, subArith, aluOp, aluSelect, bSelect, funct3
  );

endinterface

//--- alu/shifter.sv
module shifter #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]         a,
  input  logic [$clog2(WIDTH)-1:0] amt,
  input  logic                     right,
  input  logic                     arith,
  input  logic                     w64,
  output logic [WIDTH-1:0]         y
);

  localparam int AMT_W = $clog2(WIDTH);

  logic [AMT_W-1:0]   amtEff;   // Shift amount after W limit
  logic               signBit;  // Fill bit for right shifts
  logic [WIDTH-1:0]   src;      // a with W-form upper word replaced
  logic [WIDTH-1:0]   revSrc;
  logic [WIDTH-1:0]   opnd;
  logic [2*WIDTH-1:0] ext;
  logic [2*WIDTH-1:0] shifted;
  logic [WIDTH-1:0]   shr;
  logic [WIDTH-1:0]   revShr;

  // W-forms: 5-bit amount, sign from bit 31, upper word filled
  always_comb begin
    amtEff  = amt;
    signBit = arith & a[WIDTH-1];
    src     = a;
    if (w64) begin
      amtEff  = AMT_W'(amt[4:0]);
      signBit = arith & a[31];
      for (int i = 32; i < WIDTH; i++) begin
        src[i] = signBit;  // Right shift pulls these in
      end
    end
  end

  //////////////////////////////
  // One right shifter for both directions
  //////////////////////////////
  assign revSrc = {<<{src}};                // Left shift = reverse, shift right, reverse
  assign opnd   = right ? src : revSrc;
  assign ext    = {{WIDTH{right & signBit}}, opnd};  // Zero fill for left
  assign shifted = ext >> amtEff;
  assign shr    = shifted[WIDTH-1:0];
  assign revShr = {<<{shr}};
  assign y      = right ? shr : revShr;

endmodule

//--- alu/clmulUnit.sv
module clmulUnit #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0]              a,
  input  logic [WIDTH-1:0]              b,
  input  logic [aluPkg::F3_W-1:0]  funct3,
  output logic [WIDTH-1:0]              y
);

  logic [2*WIDTH-1:0] prod;  // Full carry-less product

  //////////////////////////////
  // XOR of shifted partial products
  //////////////////////////////
  always_comb begin
    prod = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (b[i]) begin
        prod = prod ^ ({{WIDTH{1'b0}}, a} << i);
      end
    end
  end

  // clmulr = rev(clmul(rev a, rev b)), which is the window one
  // below the high half of the full product
  always_comb begin
    case (funct3)
      aluPkg::F3_CLMULH: y = prod[2*WIDTH-1:WIDTH];   // High half
      aluPkg::F3_CLMULR: y = prod[2*WIDTH-2:WIDTH-1]; // Reversed
      aluPkg::F3_CLMUL:  y = prod[WIDTH-1:0];         // Low half
      default:           y = prod[WIDTH-1:0];
    endcase
  end

endmodule

//--- alu/alu.sv
module alu #(
  parameter int WIDTH = 64
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  aluCtrlIf.exe            ctrl,
  output logic [WIDTH-1:0] result,
  output logic [WIDTH-1:0] sum
);

  localparam int AMT_W = $clog2(WIDTH);

  logic [WIDTH-1:0] maskB;       // One-hot bit mask for Zbs
  logic [WIDTH-1:0] condMaskB;   // Mask or plain b
  logic [WIDTH-1:0] condInvB;    // Inverted for sub/compare/bclr
  logic [WIDTH-1:0] shiftY;
  logic [WIDTH-1:0] clmulY;
  logic [WIDTH-1:0] fullResult;  // Before W-form fixup
  logic [WIDTH-1:0] aluResult;
  logic             carry;
  logic             lt;
  logic             ltu;

  //////////////////////////////
  // Operand prep and adder
  //////////////////////////////
  assign maskB     = {{(WIDTH-1){1'b0}}, 1'b1} << b[AMT_W-1:0];
  assign condMaskB = (ctrl.bSelect == aluPkg::BSEL_ZBS) ? maskB : b;
  assign condInvB  = ctrl.subArith ? ~condMaskB : condMaskB;

  // Carry-in of 1 completes the two's complement
  assign {carry, sum} = {1'b0, a} + {1'b0, condInvB} + {{WIDTH{1'b0}}, ctrl.subArith};

  // Signed less-than from signs and difference sign
  assign lt  = (a[WIDTH-1] & ~b[WIDTH-1]) | (a[WIDTH-1] & sum[WIDTH-1])
             | (~b[WIDTH-1] & sum[WIDTH-1]);
  assign ltu = ~carry;  // Borrow out

  //////////////////////////////
  // Sub-units
  //////////////////////////////
  shifter #(.WIDTH(WIDTH)) shifter_i (
    .a     (a),
    .amt   (b[AMT_W-1:0]),
    .right (ctrl.funct3[2]),  // 001 left, 101 right
    .arith (ctrl.subArith),
    .w64   (ctrl.w64),
    .y     (shiftY)
  );

  clmulUnit #(.WIDTH(WIDTH)) clmulUnit_i (
    .a      (a),
    .b      (b),
    .funct3 (ctrl.funct3),
    .y      (clmulY)
  );

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    if (!ctrl.aluOp) begin
      fullResult = sum;  // Address generation
    end else begin
      case (ctrl.aluSelect)
        aluPkg::SEL_SUM:   fullResult = sum;                          // add, sub
        aluPkg::SEL_SHIFT: fullResult = shiftY;                       // sll, srl, sra
        aluPkg::SEL_SLT:   fullResult = {{(WIDTH-1){1'b0}}, lt};
        aluPkg::SEL_SLTU:  fullResult = {{(WIDTH-1){1'b0}}, ltu};
        aluPkg::SEL_XOR:   fullResult = a ^ condMaskB;                // xor, binv
        aluPkg::SEL_BEXT:  fullResult = {{(WIDTH-1){1'b0}}, |(a & condMaskB)};
        aluPkg::SEL_OR:    fullResult = a | condMaskB;                // or, bset
        default:           fullResult = a & condInvB;                 // and, bclr
      endcase
    end
  end

  // W-forms keep the low word, sign-extended
  always_comb begin
    aluResult = fullResult;
    if (ctrl.w64) begin
      for (int i = 32; i < WIDTH; i++) begin
        aluResult[i] = fullResult[31];
      end
    end
  end

  always_comb begin
    case (ctrl.bSelect)
      aluPkg::BSEL_ZBS: result = fullResult;  // Never a W-form
      aluPkg::BSEL_ZBC: result = clmulY;
      default:          result = aluResult;
    endcase
  end

  // Decoder never asks for both bit-manip groups
  assert property (@(posedge ctrl.clk) disable iff (!ctrl.rstN)
    $onehot0(ctrl.bSelect));

  // W-form classes are only legal on an RV64 datapath
  assert property (@(posedge ctrl.clk) disable iff (!ctrl.rstN)
    (WIDTH != 32) || !ctrl.w64);

endmodule

//--- rtl/aluDecoder.sv
module aluDecoder (
  input  aluPkg::opClassT            opClass,
  input  logic [aluPkg::F3_W-1:0]    funct3,
  input  logic [aluPkg::F7_W-1:0]    funct7,
  aluCtrlIf.dec                      ctrl
);

  logic isReg;   // Register source, incl. W
  logic isImm;   // Immediate source, incl. W
  logic isWord;  // W-form class
  logic altBit;  // funct7 bit 5, sub/sra

  // Class flags; unknown class falls to address add
  always_comb begin
    isReg  = 1'b0;
    isImm  = 1'b0;
    isWord = 1'b0;
    case (opClass)
      aluPkg::opReg: isReg = 1'b1;
      aluPkg::opImm: isImm = 1'b1;
      aluPkg::opReg32: begin
        isReg  = 1'b1;
        isWord = 1'b1;
      end
      aluPkg::opImm32: begin
        isImm  = 1'b1;
        isWord = 1'b1;
      end
      default: ;  // opAddr
    endcase
  end

  assign altBit = |(funct7 & aluPkg::F7_ALT);

  always_comb begin
    ctrl.funct3    = funct3;
    ctrl.w64       = isWord;
    ctrl.aluOp     = isReg | isImm;
    ctrl.subArith  = 1'b0;
    ctrl.aluSelect = aluPkg::SEL_SUM;
    ctrl.bSelect   = aluPkg::BSEL_NONE;

    //////////////////////////////
    // Base RV32I/RV64I ops
    //////////////////////////////
    if (isReg | isImm) begin
      case (funct3)
        aluPkg::F3_ADD: ctrl.subArith = isReg & altBit;  // No subi
        aluPkg::F3_SLL: ctrl.aluSelect = aluPkg::SEL_SHIFT;
        aluPkg::F3_SLT: begin
          ctrl.aluSelect = aluPkg::SEL_SLT;
          ctrl.subArith  = 1'b1;  // Compare via a - b
        end
        aluPkg::F3_SLTU: begin
          ctrl.aluSelect = aluPkg::SEL_SLTU;
          ctrl.subArith  = 1'b1;
        end
        aluPkg::F3_XOR: ctrl.aluSelect = aluPkg::SEL_XOR;
        aluPkg::F3_SR: begin
          ctrl.aluSelect = aluPkg::SEL_SHIFT;
          ctrl.subArith  = altBit;  // sra/srai
        end
        aluPkg::F3_OR:  ctrl.aluSelect = aluPkg::SEL_OR;
        default:        ctrl.aluSelect = aluPkg::SEL_AND;
      endcase

      // Zbs; bit 0 of funct7 is shamt[5] on immediates
      if (!isWord && funct3 == aluPkg::F3_SLL) begin
        if (funct7[6:1] == aluPkg::F7_BSET[6:1]) begin
          ctrl.bSelect   = aluPkg::BSEL_ZBS;
          ctrl.aluSelect = aluPkg::SEL_OR;
        end else if (funct7[6:1] == aluPkg::F7_BCLR_BEXT[6:1]) begin
          ctrl.bSelect   = aluPkg::BSEL_ZBS;
          ctrl.aluSelect = aluPkg::SEL_AND;
          ctrl.subArith  = 1'b1;  // a & ~mask
        end else if (funct7[6:1] == aluPkg::F7_BINV[6:1]) begin
          ctrl.bSelect   = aluPkg::BSEL_ZBS;
          ctrl.aluSelect = aluPkg::SEL_XOR;
        end
      end else if (!isWord && funct3 == aluPkg::F3_SR &&
                   funct7[6:1] == aluPkg::F7_BCLR_BEXT[6:1]) begin
        ctrl.bSelect   = aluPkg::BSEL_ZBS;  // bext
        ctrl.aluSelect = aluPkg::SEL_BEXT;
        ctrl.subArith  = 1'b0;               // Bit 5 is not sra here
      end

      // Zbc, register form only
      if (isReg && !isWord && funct7 == aluPkg::F7_ZBC &&
          (funct3 == aluPkg::F3_CLMUL || funct3 == aluPkg::F3_CLMULR ||
           funct3 == aluPkg::F3_CLMULH)) begin
        ctrl.bSelect   = aluPkg::BSEL_ZBC;
        ctrl.aluSelect = aluPkg::SEL_SUM;
        ctrl.subArith  = 1'b0;  // Keep sum as a + b
      end
    end
  end

endmodule

//--- rtl/intExecute.sv
module intExecute #(
  parameter int WIDTH = 64
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         valid,
  input  aluPkg::opClassT              opClass,
  input  logic [aluPkg::F3_W-1:0]      funct3,
  input  logic [aluPkg::F7_W-1:0]      funct7,
  input  logic [WIDTH-1:0]             a,
  input  logic [WIDTH-1:0]             b,
  output logic                         resultValid,
  output logic [WIDTH-1:0]             result,
  output logic [WIDTH-1:0]             sum
);

  logic                       opValid;   // Input stage valid
  aluPkg::opClassT            opClassQ;
  logic [aluPkg::F3_W-1:0]    funct3Q;
  logic [aluPkg::F7_W-1:0]    funct7Q;
  logic [WIDTH-1:0]           aQ;
  logic [WIDTH-1:0]           bQ;
  logic [WIDTH-1:0]           aluResult;
  logic [WIDTH-1:0]           aluSum;

  //////////////////////////////
  // Input stage
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) opValid <= 1'b0;
    else       opValid <= valid;
  end

  always_ff @(posedge clk) begin
    if (valid) begin  // Hold operands between strobes
      opClassQ <= opClass;
      funct3Q  <= funct3;
      funct7Q  <= funct7;
      aQ       <= a;
      bQ       <= b;
    end
  end

  //////////////////////////////
  // Decode and execute, combinational
  //////////////////////////////
  aluCtrlIf ctrlIf (.clk(clk), .rstN(rstN));

  aluDecoder aluDecoder_i (
    .opClass (opClassQ),
    .funct3  (funct3Q),
    .funct7  (funct7Q),
    .ctrl    (ctrlIf.dec)
  );

  alu #(.WIDTH(WIDTH)) alu_i (
    .a      (aQ),
    .b      (bQ),
    .ctrl   (ctrlIf.exe),
    .result (aluResult),
    .sum    (aluSum)
  );

  // Result stage
  always_ff @(posedge clk) begin
    if (!rstN) resultValid <= 1'b0;
    else       resultValid <= opValid;
  end

  always_ff @(posedge clk) begin
    if (opValid) begin
      result <= aluResult;
      sum    <= aluSum;
    end
  end

  // Strobe stays clean for the consumer after reset
  assert property (@(posedge clk) disable iff (!rstN) !$isunknown(resultValid));

endmodule

//--- verif/clkGen.sv
module clkGen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a clock edge, as a synchronous reset source would
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

//--- verif/aluRefModel.svh
// Reference results from the RV64I, Zbs and Zbc definitions
// Operations are named by mnemonic, "addr" is address generation

function automatic logic [63:0] sext32(logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// Bit-serial carry-less product; kind 0 clmul, 1 clmulh, 2 clmulr
function automatic logic [63:0] clmulRef(logic [63:0] x, logic [63:0] y, int kind);
  logic [63:0] acc;
  acc = '0;
  for (int i = 0; i < 64; i++) begin
    if (y[i]) begin
      if (kind == 0) acc = acc ^ (x << i);
      else if (kind == 1 && i > 0) acc = acc ^ (x >> (64 - i));  // Upper half
      else if (kind == 2) acc = acc ^ (x >> (63 - i));
    end
  end
  return acc;
endfunction

function automatic logic [63:0] refResult(string op, logic [63:0] x, logic [63:0] y);
  logic [5:0]  sh;    // RV64 shift amount and Zbs index
  logic [4:0]  shw;   // W-form amount
  logic [63:0] oneHot;
  sh     = y[5:0];
  shw    = y[4:0];
  oneHot = 64'd1 << sh;
  case (op)
    "add", "addi":   return x + y;
    "sub":           return x - y;
    "slt", "slti":   return {63'd0, ($signed(x) < $signed(y))};
    "sltu", "sltiu": return {63'd0, (x < y)};
    "xor", "xori":   return x ^ y;
    "or", "ori":     return x | y;
    "and", "andi":   return x & y;
    "sll", "slli":   return x << sh;
    "srl", "srli":   return x >> sh;
    "sra", "srai":   return $signed(x) >>> sh;
    "addw", "addiw": return sext32(x[31:0] + y[31:0]);
    "subw":          return sext32(x[31:0] - y[31:0]);
    "sllw", "slliw": return sext32(x[31:0] << shw);
    "srlw", "srliw": return sext32(x[31:0] >> shw);
    "sraw", "sraiw": return sext32($signed(x[31:0]) >>> shw);
    "bset", "bseti": return x | oneHot;
    "bclr", "bclri": return x & ~oneHot;
    "binv", "binvi": return x ^ oneHot;
    "bext", "bexti": return {63'd0, x[sh]};
    "clmul":         return clmulRef(x, y, 0);
    "clmulh":        return clmulRef(x, y, 1);
    "clmulr":        return clmulRef(x, y, 2);
    default:         return x + y;  // addr
  endcase
endfunction

// Adder output, a - b for subtract and compare
function automatic logic [63:0] refSum(string op, logic [63:0] x, logic [63:0] y);
  case (op)
    "sub", "subw", "slt", "slti", "sltu", "sltiu": return x - y;
    default: return x + y;
  endcase
endfunction

// Shift and Zbs ops leave the adder output undefined
function automatic bit sumDefined(string op);
  case (op)
    "sll", "slli", "srl", "srli", "sra", "srai":                  return 1'b0;
    "sllw", "slliw", "srlw", "srliw", "sraw", "sraiw":            return 1'b0;
    "bset", "bseti", "bclr", "bclri", "binv", "binvi":            return 1'b0;
    "bext", "bexti":                                              return 1'b0;
    default:                                                      return 1'b1;
  endcase
endfunction

//--- verif/tbIntExecute.sv
module tbIntExecute;

  localparam int WIDTH        = 64;
  localparam int RESET_CYCLES = 16;
  localparam int RESET_LIMIT  = 100;  // Cycles allowed for reset release
  localparam int DRAIN_LIMIT  = 50;   // Cycles allowed for results to come back

  logic            clk;
  logic            rstN;
  logic            valid;
  aluPkg::opClassT opClass;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  logic            resultValid;
  logic [WIDTH-1:0] result;
  logic [WIDTH-1:0] sum;

  logic [31:0] lfsr = 32'h5c7f_3e9b;
  int cycleCnt  = 0;
  int errCount  = 0;
  int opCount   = 0;
  int testCount = 0;
  bit timedOut  = 1'b0;
  string curTest = "reset";  // Group whose results are in flight

  // Supported operations
  string           opName[$];
  aluPkg::opClassT opCls[$];
  logic [2:0]      opF3[$];
  logic [6:0]      opF7[$];

  // Expected responses in issue order
  logic [WIDTH-1:0] expResQ[$];
  logic [WIDTH-1:0] expSumQ[$];
  bit               sumChkQ[$];
  int               cycQ[$];   // Edge that drove the strobe
  string            nameQ[$];

  `include "aluRefModel.svh"

  clkGen #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) clkGen_i (.clk(clk), .rstN(rstN));

  intExecute #(.WIDTH(WIDTH)) intExecute_i (
    .clk         (clk),
    .rstN        (rstN),
    .valid       (valid),
    .opClass     (opClass),
    .funct3      (funct3),
    .funct7      (funct7),
    .a           (a),
    .b           (b),
    .resultValid (resultValid),
    .result      (result),
    .sum         (sum)
  );

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  //////////////////////////////
  // Random numbers
  //////////////////////////////
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [63:0] randBits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);  // One step per bit
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic addOp(string n, aluPkg::opClassT c, logic [2:0] f3, logic [6:0] f7);
    opName.push_back(n);
    opCls.push_back(c);
    opF3.push_back(f3);
    opF7.push_back(f7);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic issueOp(int idx);
    logic [WIDTH-1:0] av;
    logic [WIDTH-1:0] bv;
    logic [2:0]       f3;
    logic [6:0]       f7;
    av = randBits(64);
    bv = randBits(64);
    f3 = opF3[idx];
    f7 = opF7[idx];
    if (opCls[idx] == aluPkg::opAddr) begin  // Fields ignored for address add
      f3 = 3'(randBits(3));
      f7 = 7'(randBits(7));
    end
    @(posedge clk);
    valid   <= 1'b1;
    opClass <= opCls[idx];
    funct3  <= f3;
    funct7  <= f7;
    a       <= av;
    b       <= bv;
    expResQ.push_back(refResult(opName[idx], av, bv));
    expSumQ.push_back(refSum(opName[idx], av, bv));
    sumChkQ.push_back(sumDefined(opName[idx]));
    cycQ.push_back(cycleCnt + 1);  // cycleCnt not yet stepped on this edge
    nameQ.push_back(opName[idx]);
    opCount++;
  endtask

  task automatic idleCycle();
    @(posedge clk);
    valid <= 1'b0;
  endtask

  task automatic drainResults(output bit ok);
    int waited;
    waited = 0;
    while (expResQ.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    ok = (expResQ.size() == 0);
  endtask

  // Random ops from table rows lo..hi, gap of 0 gives back-to-back strobes
  task automatic runGroup(string grp, int lo, int hi, int n, int errBase);
    int idx;
    int gap;
    bit ok;
    curTest = grp;
    for (int i = 0; i < n; i++) begin
      gap = int'(randBits(2));
      for (int g = 0; g < gap; g++) idleCycle();
      idx = lo + int'(randBits(8)) % (hi - lo + 1);
      issueOp(idx);
    end
    idleCycle();
    drainResults(ok);
    testCount++;
    if (!ok) begin
      $display("Timeout in test %s with %0d results never returned", grp, expResQ.size());
      timedOut = 1'b1;
    end
    $display("Test %-6s %3d operations, %0d errors", grp, n, errCount - errBase);
  endtask

  //////////////////////////////
  // Response checking
  //////////////////////////////
  always @(negedge clk) begin
    logic [WIDTH-1:0] er;
    logic [WIDTH-1:0] es;
    bit               chk;
    int               cyc;
    string            nm;
    if (cycleCnt != 0 && resultValid !== 1'b0) begin  // X counts as a strobe too
      assert (expResQ.size() != 0) else begin
        $display("resultValid high at cycle %0d with no operation outstanding", cycleCnt);
        errCount++;
      end
      if (expResQ.size() != 0) begin
        er  = expResQ.pop_front();
        es  = expSumQ.pop_front();
        chk = sumChkQ.pop_front();
        cyc = cycQ.pop_front();
        nm  = nameQ.pop_front();
        assert (cycleCnt == cyc + 2) else begin
          $display("ERROR %s %s latency: expected %0d, actual %0d", curTest, nm, 2,
                   cycleCnt - cyc);
          errCount++;
        end
        assert (result === er) else begin
          $display("ERROR %s %s result: expected %h, actual %h", curTest, nm, er, result);
          errCount++;
        end
        if (chk) begin
          assert (sum === es) else begin
            $display("ERROR %s %s sum: expected %h, actual %h", curTest, nm, es, sum);
            errCount++;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int waited;
    valid   = 1'b0;
    opClass = aluPkg::opReg;
    funct3  = '0;
    funct7  = '0;
    a       = '0;
    b       = '0;

    // Rows 0-12 base, 13-27 shift and W, 28-35 Zbs, 36-38 Zbc, 39 addr
    addOp("add",   aluPkg::opReg,   aluPkg::F3_ADD,   aluPkg::F7_BASE);
    addOp("sub",   aluPkg::opReg,   aluPkg::F3_ADD,   aluPkg::F7_ALT);
    addOp("slt",   aluPkg::opReg,   aluPkg::F3_SLT,   aluPkg::F7_BASE);
    addOp("sltu",  aluPkg::opReg,   aluPkg::F3_SLTU,  aluPkg::F7_BASE);
    addOp("xor",   aluPkg::opReg,   aluPkg::F3_XOR,   aluPkg::F7_BASE);
    addOp("or",    aluPkg::opReg,   aluPkg::F3_OR,    aluPkg::F7_BASE);
    addOp("and",   aluPkg::opReg,   aluPkg::F3_AND,   aluPkg::F7_BASE);
    addOp("addi",  aluPkg::opImm,   aluPkg::F3_ADD,   aluPkg::F7_BASE);
    addOp("slti",  aluPkg::opImm,   aluPkg::F3_SLT,   aluPkg::F7_BASE);
    addOp("sltiu", aluPkg::opImm,   aluPkg::F3_SLTU,  aluPkg::F7_BASE);
    addOp("xori",  aluPkg::opImm,   aluPkg::F3_XOR,   aluPkg::F7_BASE);
    addOp("ori",   aluPkg::opImm,   aluPkg::F3_OR,    aluPkg::F7_BASE);
    addOp("andi",  aluPkg::opImm,   aluPkg::F3_AND,   aluPkg::F7_BASE);
    addOp("sll",   aluPkg::opReg,   aluPkg::F3_SLL,   aluPkg::F7_BASE);
    addOp("srl",   aluPkg::opReg,   aluPkg::F3_SR,    aluPkg::F7_BASE);
    addOp("sra",   aluPkg::opReg,   aluPkg::F3_SR,    aluPkg::F7_ALT);
    addOp("slli",  aluPkg::opImm,   aluPkg::F3_SLL,   aluPkg::F7_BASE);
    addOp("srli",  aluPkg::opImm,   aluPkg::F3_SR,    aluPkg::F7_BASE);
    addOp("srai",  aluPkg::opImm,   aluPkg::F3_SR,    aluPkg::F7_ALT);
    addOp("addw",  aluPkg::opReg32, aluPkg::F3_ADD,   aluPkg::F7_BASE);
    addOp("subw",  aluPkg::opReg32, aluPkg::F3_ADD,   aluPkg::F7_ALT);
    addOp("sllw",  aluPkg::opReg32, aluPkg::F3_SLL,   aluPkg::F7_BASE);
    addOp("srlw",  aluPkg::opReg32, aluPkg::F3_SR,    aluPkg::F7_BASE);
    addOp("sraw",  aluPkg::opReg32, aluPkg::F3_SR,    aluPkg::F7_ALT);
    addOp("addiw", aluPkg::opImm32, aluPkg::F3_ADD,   aluPkg::F7_BASE);
    addOp("slliw", aluPkg::opImm32, aluPkg::F3_SLL,   aluPkg::F7_BASE);
    addOp("srliw", aluPkg::opImm32, aluPkg::F3_SR,    aluPkg::F7_BASE);
    addOp("sraiw", aluPkg::opImm32, aluPkg::F3_SR,    aluPkg::F7_ALT);
    addOp("bset",  aluPkg::opReg,   aluPkg::F3_SLL,   aluPkg::F7_BSET);
    addOp("bclr",  aluPkg::opReg,   aluPkg::F3_SLL,   aluPkg::F7_BCLR_BEXT);
    addOp("binv",  aluPkg::opReg,   aluPkg::F3_SLL,   aluPkg::F7_BINV);
    addOp("bext",  aluPkg::opReg,   aluPkg::F3_SR,    aluPkg::F7_BCLR_BEXT);
    addOp("bseti", aluPkg::opImm,   aluPkg::F3_SLL,   aluPkg::F7_BSET);
    addOp("bclri", aluPkg::opImm,   aluPkg::F3_SLL,   aluPkg::F7_BCLR_BEXT);
    addOp("binvi", aluPkg::opImm,   aluPkg::F3_SLL,   aluPkg::F7_BINV);
    addOp("bexti", aluPkg::opImm,   aluPkg::F3_SR,    aluPkg::F7_BCLR_BEXT);
    addOp("clmul", aluPkg::opReg,   aluPkg::F3_CLMUL, aluPkg::F7_ZBC);
    addOp("clmulh", aluPkg::opReg,  aluPkg::F3_CLMULH, aluPkg::F7_ZBC);
    addOp("clmulr", aluPkg::opReg,  aluPkg::F3_CLMULR, aluPkg::F7_ZBC);
    addOp("addr",  aluPkg::opAddr,  aluPkg::F3_ADD,   aluPkg::F7_BASE);

    // Strobes through reset up to the last edge that still sees rstN low
    waited = 0;
    while (rstN !== 1'b1 && waited < RESET_LIMIT) begin
      @(posedge clk);
      waited++;
      if (cycleCnt < RESET_CYCLES - 1) begin
        valid <= 1'b1;
        a     <= randBits(64);
        b     <= randBits(64);
      end else begin
        valid <= 1'b0;
      end
    end
    if (rstN !== 1'b1) begin
      $display("Timeout waiting for reset release");
      timedOut = 1'b1;
    end

    if (!timedOut) begin
      repeat (3) idleCycle();  // Monitor flags any stray resultValid here
      runGroup("reset", 0, 0, 1, 0);
    end
    if (!timedOut) runGroup("base", 0, 12, 80, errCount);
    if (!timedOut) runGroup("shift", 13, 27, 90, errCount);
    if (!timedOut) runGroup("zbs", 28, 35, 60, errCount);
    if (!timedOut) runGroup("zbc", 36, 38, 40, errCount);
    if (!timedOut) runGroup("addr", 39, 39, 30, errCount);

    $display("Tests: %0d, operations: %0d, errors: %0d", testCount, opCount, errCount);
    if (errCount == 0 && !timedOut) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verif
common/aluPkg.sv
common/aluCtrlIf.sv
alu/shifter.sv
alu/clmulUnit.sv
alu/alu.sv
rtl/aluDecoder.sv
rtl/intExecute.sv
verif/clkGen.sv
verif/tbIntExecute.sv

//--- Makefile
# Verilator build and run of the intExecute testbench

VERILATOR ?= verilator
TOP       ?= tbIntExecute
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
